// File: alu_pkg.sv
// alu_pkg
// shared widths, queue and credit depths, opcode encoding and vector types
// for the pipelined 8-bit ALU

package alu_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // operand and result width
    localparam int unsigned DATA_W = 8;
    // multiplier operand width, also the number of multiplier layers
    localparam int unsigned MUL_W = 4;
    // shift and rotate amount taken from b
    localparam int unsigned SHAMT_W = 3;

    ////////////////////////////////////////
    // flow control
    ////////////////////////////////////////

    // input queue depth, equal to the input credits held by the source
    localparam int unsigned IN_DEPTH = 4;
    // output credits held by the issue stage after reset
    localparam int unsigned OUT_CREDITS = 4;

    // queue pointer, queue occupancy and credit counter widths
    localparam int unsigned QPTR_W = $clog2(IN_DEPTH);
    localparam int unsigned QCNT_W = $clog2(IN_DEPTH + 1);
    localparam int unsigned CRED_W = $clog2(OUT_CREDITS + 1);

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    // operands and results
    typedef logic [DATA_W-1:0] data_t;
    // multiplier nibbles and partial sums
    typedef logic [MUL_W-1:0] nib_t;

    // opcode, encoded from 0 upward in this order
    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_rsb,
        op_mul,
        op_nor,
        op_not,
        op_nand,
        op_xnor,
        op_srl,
        op_sll,
        op_ror,
        op_rol,
        op_nop0,
        op_nop1,
        op_nop2,
        op_nop3
    } alu_op_t;

endpackage

// File: alu_issue.sv
// alu_issue
// input queue of pending operations with input-credit return, and the
// output credit counter that decides when the head may launch.
// one operation launches per cycle onto the stage-0 pipeline signals

`timescale 1ns/10ps

module alu_issue
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  alu_op_t in_op,
    input  data_t   in_a,
    input  data_t   in_b,
    input  logic    out_credit,
    output logic    in_credit,
    output logic    s_valid,
    output alu_op_t s_op,
    output data_t   s_a,
    output data_t   s_b,
    output nib_t    s_pp,
    output nib_t    s_prod
);

    // queue storage
    alu_op_t q_op [IN_DEPTH];
    data_t   q_a  [IN_DEPTH];
    data_t   q_b  [IN_DEPTH];

    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] q_cnt;
    logic [CRED_W-1:0] out_cnt;

    logic q_empty;
    logic push;
    logic pop;

    ////////////////////////////////////////
    // issue decision
    ////////////////////////////////////////

    assign q_empty = (q_cnt == '0);

    // the source only sends while it holds a credit
    assign push = in_valid;
    // head launches once there is room downstream
    assign pop  = !q_empty && (out_cnt != '0);

    ////////////////////////////////////////
    // queue
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            q_op[wr_ptr] <= in_op;
            q_a[wr_ptr]  <= in_a;
            q_b[wr_ptr]  <= in_b;
        end
    end

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy, push and pop in one cycle cancel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_cnt <= '0;
        end else if (push && !pop) begin
            q_cnt <= q_cnt + 1'b1;
        end else if (pop && !push) begin
            q_cnt <= q_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////
    // credits
    ////////////////////////////////////////

    // output credits, a pop spends one and a sink pulse returns one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_cnt <= CRED_W'(OUT_CREDITS);
        end else if (out_credit && !pop) begin
            out_cnt <= out_cnt + 1'b1;
        end else if (pop && !out_credit) begin
            out_cnt <= out_cnt - 1'b1;
        end
    end

    // each freed queue slot goes back to the source one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop;
        end
    end

    ////////////////////////////////////////
    // stage 0
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_valid <= 1'b0;
        end else begin
            s_valid <= pop;
        end
    end

    // multiplier starts from an empty partial sum
    always_ff @(posedge clk) begin
        if (pop) begin
            s_op   <= q_op[rd_ptr];
            s_a    <= q_a[rd_ptr];
            s_b    <= q_b[rd_ptr];
            s_pp   <= '0;
            s_prod <= '0;
        end
    end

endmodule

// File: mult_layer.sv
// mult_layer
// one registered row of the array multiplier; adds a times b[LAYER] to the
// running partial sum, retires one product bit and carries the operation on

`timescale 1ns/10ps

module mult_layer
    import alu_pkg::*;
#(
    parameter int unsigned LAYER = 0
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    i_valid,
    input  alu_op_t i_op,
    input  data_t   i_a,
    input  data_t   i_b,
    input  nib_t    i_pp,
    input  nib_t    i_prod,
    output logic    o_valid,
    output alu_op_t o_op,
    output data_t   o_a,
    output data_t   o_b,
    output nib_t    o_pp,
    output nib_t    o_prod
);

    // scalar product of the low nibble of a with one bit of b
    nib_t           tt;
    // one carry bit above the nibble
    logic [MUL_W:0] sum;
    nib_t           prod_nxt;

    always_comb begin
        tt  = i_a[MUL_W-1:0] & {MUL_W{i_b[LAYER]}};
        sum = {1'b0, tt} + {1'b0, i_pp};
        // lsb of the sum is final, it lands at weight LAYER
        prod_nxt        = i_prod;
        prod_nxt[LAYER] = sum[0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // upper bits of the sum move down one weight for the next row
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_op   <= i_op;
            o_a    <= i_a;
            o_b    <= i_b;
            o_pp   <= sum[MUL_W:1];
            o_prod <= prod_nxt;
        end
    end

endmodule

// File: alu_result.sv
// alu_result
// final stage: evaluates the opcode on the carried operands, picks up the
// finished product from the last multiplier layer and registers the result
// with its signed overflow flag

`timescale 1ns/10ps

module alu_result
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    i_valid,
    input  alu_op_t i_op,
    input  data_t   i_a,
    input  data_t   i_b,
    input  nib_t    i_pp,
    input  nib_t    i_prod,
    output logic    res_valid,
    output data_t   res_data,
    output logic    res_ovf
);

    data_t prod;
    data_t sum_ab;
    data_t dif_ab;
    data_t dif_ba;

    logic [SHAMT_W-1:0]  shamt;
    // a concatenated with itself, so rotates become plain shifts
    logic [2*DATA_W-1:0] dbl_r;
    logic [2*DATA_W-1:0] dbl_l;

    data_t res_nxt;
    logic  ovf_nxt;

    // sign bits
    logic sa;
    logic sb;

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    // high nibble is the last partial sum, low nibble the retired bits
    assign prod = {i_pp, i_prod};

    assign sum_ab = i_a + i_b;
    assign dif_ab = i_a - i_b;
    assign dif_ba = i_b - i_a;

    assign sa = i_a[DATA_W-1];
    assign sb = i_b[DATA_W-1];

    assign shamt = i_b[SHAMT_W-1:0];
    assign dbl_r = {i_a, i_a} >> shamt;
    assign dbl_l = {i_a, i_a} << shamt;

    ////////////////////////////////////////
    // opcode select
    ////////////////////////////////////////

    always_comb begin
        res_nxt = '0;
        ovf_nxt = 1'b0;
        case (i_op)
            op_add: begin
                res_nxt = sum_ab;
                // same signs in, other sign out
                ovf_nxt = (sa == sb) && (sum_ab[DATA_W-1] != sa);
            end
            op_sub: begin
                res_nxt = dif_ab;
                ovf_nxt = (sa != sb) && (dif_ab[DATA_W-1] != sa);
            end
            op_rsb: begin
                res_nxt = dif_ba;
                // minuend is b here
                ovf_nxt = (sa != sb) && (dif_ba[DATA_W-1] != sb);
            end
            op_mul: begin
                res_nxt = prod;
            end
            op_nor: begin
                res_nxt = ~(i_a | i_b);
            end
            op_not: begin
                res_nxt = ~i_a;
            end
            op_nand: begin
                res_nxt = ~(i_a & i_b);
            end
            op_xnor: begin
                res_nxt = ~(i_a ^ i_b);
            end
            op_srl: begin
                res_nxt = i_a >> shamt;
            end
            op_sll: begin
                res_nxt = i_a << shamt;
            end
            // low half of the doubled word after a right shift
            op_ror: begin
                res_nxt = dbl_r[DATA_W-1:0];
            end
            // high half after a left shift
            op_rol: begin
                res_nxt = dbl_l[2*DATA_W-1:DATA_W];
            end
            // the four nop codes give zero
            default: begin
                res_nxt = '0;
            end
        endcase
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            res_data <= res_nxt;
            res_ovf  <= ovf_nxt;
        end
    end

endmodule

// File: alu_top.sv
// alu_top
// pipelined 8-bit ALU: issue queue with credit flow control on both sides,
// a chain of registered multiplier layers, and the result stage

`timescale 1ns/10ps

module alu_top
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  alu_op_t in_op,
    input  data_t   in_a,
    input  data_t   in_b,
    output logic    in_credit,
    output logic    res_valid,
    output data_t   res_data,
    output logic    res_ovf,
    input  logic    out_credit
);

    // stage k feeds layer k, stage MUL_W feeds the result stage
    logic    st_valid [MUL_W+1];
    alu_op_t st_op    [MUL_W+1];
    data_t   st_a     [MUL_W+1];
    data_t   st_b     [MUL_W+1];
    nib_t    st_pp    [MUL_W+1];
    nib_t    st_prod  [MUL_W+1];

    alu_issue u_issue (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .s_valid    (st_valid[0]),
        .s_op       (st_op[0]),
        .s_a        (st_a[0]),
        .s_b        (st_b[0]),
        .s_pp       (st_pp[0]),
        .s_prod     (st_prod[0])
    );

    // one layer per bit of the b nibble
    for (genvar i = 0; i < MUL_W; i++) begin : g_layer
        mult_layer #(
            .LAYER (i)
        ) u_layer (
            .clk     (clk),
            .arst_n  (arst_n),
            .i_valid (st_valid[i]),
            .i_op    (st_op[i]),
            .i_a     (st_a[i]),
            .i_b     (st_b[i]),
            .i_pp    (st_pp[i]),
            .i_prod  (st_prod[i]),
            .o_valid (st_valid[i+1]),
            .o_op    (st_op[i+1]),
            .o_a     (st_a[i+1]),
            .o_b     (st_b[i+1]),
            .o_pp    (st_pp[i+1]),
            .o_prod  (st_prod[i+1])
        );
    end

    alu_result u_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .i_valid   (st_valid[MUL_W]),
        .i_op      (st_op[MUL_W]),
        .i_a       (st_a[MUL_W]),
        .i_b       (st_b[MUL_W]),
        .i_pp      (st_pp[MUL_W]),
        .i_prod    (st_prod[MUL_W]),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_ovf   (res_ovf)
    );

endmodule

// File: alu_checker.sv
// alu_checker
// credit and queue rules of the issue stage, bound into every alu_issue

`timescale 1ns/10ps

module alu_checker
    import alu_pkg::*;
(
    input logic              clk,
    input logic              arst_n,
    input logic              push,
    input logic              pop,
    input logic              out_credit,
    input logic [CRED_W-1:0] out_cnt,
    input logic              in_credit
);

    // entries pushed and not yet popped
    int held;
    // output credits spent and not yet returned by the sink
    int spent;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held  <= 0;
            spent <= 0;
        end else begin
            held  <= held + int'(push) - int'(pop);
            spent <= spent + int'(pop) - int'(out_credit);
        end
    end

    // a push into a full queue means the source sent without a credit
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> (held < int'(IN_DEPTH))
    ) else $error("push into a full input queue");

    // head only launches with an entry and room downstream
    a_pop_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
            pop |-> (held > 0 && spent < int'(OUT_CREDITS))
    ) else $error("pop from an empty queue or without an output credit");

    // sink can never return more than it was given
    a_cnt_bound: assert property (
        @(posedge clk) disable iff (!arst_n) out_cnt <= CRED_W'(OUT_CREDITS)
    ) else $error("output credit counter above its reset value");

    // nothing popped yet on the first edge out of reset
    a_credit_after_rst: assert property (
        @(posedge clk) $rose(arst_n) |-> !in_credit
    ) else $error("in_credit high in the first cycle after reset");

endmodule

bind alu_issue alu_checker u_checker (
    .clk        (clk),
    .arst_n     (arst_n),
    .push       (push),
    .pop        (pop),
    .out_credit (out_credit),
    .out_cnt    (out_cnt),
    .in_credit  (in_credit)
);

// File: tb_alu_top.sv
// tb_alu_top
// random credit-respecting stimulus for the pipelined ALU, a reference
// model with an in-order scoreboard, and a sink that returns credits late

`timescale 1ns/10ps

module tb_alu_top
    import alu_pkg::*;
();

    localparam int N_ARITH = 300;
    localparam int N_LOGIC = 200;
    localparam int N_SHIFT = 160;
    localparam int N_FLOW  = 200;
    localparam int N_TOTAL = N_ARITH + N_LOGIC + N_SHIFT + N_FLOW;
    // generous per-operation budget for the watchdog
    localparam int MAX_CYC = N_TOTAL * 20 + 200;

    logic    clk;
    logic    arst_n;
    logic    in_valid;
    alu_op_t in_op;
    data_t   in_a;
    data_t   in_b;
    logic    in_credit;
    logic    res_valid;
    data_t   res_data;
    logic    res_ovf;
    logic    out_credit;

    int seed;
    // operations waiting at the source, and what the model expects back
    alu_op_t pend_op [$];
    data_t   pend_a [$];
    data_t   pend_b [$];
    data_t   exp_data [$];
    logic    exp_ovf [$];
    // cycles each received result waits before its credit goes back
    int      sink_dly [$];

    int   src_cnt = IN_DEPTH;
    int   queued_cnt = 0;
    int   checked_cnt = 0;
    int   sent_cnt = 0;
    int   credit_pulses = 0;
    int   credits_back = 0;
    logic sink_hold = 1'b0;

    alu_top u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_ovf    (res_ovf),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // returns {ovf, data}
    function automatic logic [DATA_W:0] model_alu(alu_op_t op, data_t a, data_t b);
        int    sa;
        int    sb;
        int    wide;
        data_t r;
        logic  ovf;
        sa   = $signed(a);
        sb   = $signed(b);
        wide = 0;
        r    = '0;
        ovf  = 1'b0;
        case (op)
            op_add:  wide = sa + sb;
            op_sub:  wide = sa - sb;
            op_rsb:  wide = sb - sa;
            op_mul:  r = data_t'(int'(a[MUL_W-1:0]) * int'(b[MUL_W-1:0]));
            op_nor:  r = ~a & ~b;
            op_not:  r = ~a;
            op_nand: r = ~a | ~b;
            op_xnor: r = a ^ ~b;
            op_srl: begin
                r = a;
                for (int i = 0; i < b[SHAMT_W-1:0]; i++) begin
                    r = {1'b0, r[DATA_W-1:1]};
                end
            end
            op_sll: begin
                r = a;
                for (int i = 0; i < b[SHAMT_W-1:0]; i++) begin
                    r = {r[DATA_W-2:0], 1'b0};
                end
            end
            op_ror: begin
                r = a;
                for (int i = 0; i < b[SHAMT_W-1:0]; i++) begin
                    r = {r[0], r[DATA_W-1:1]};
                end
            end
            op_rol: begin
                r = a;
                for (int i = 0; i < b[SHAMT_W-1:0]; i++) begin
                    r = {r[DATA_W-2:0], r[DATA_W-1]};
                end
            end
            default: r = '0;
        endcase
        // signed overflow when the true result leaves the 8-bit range
        if (op == op_add || op == op_sub || op == op_rsb) begin
            r   = data_t'(wide);
            ovf = (wide > 127) || (wide < -128);
        end
        return {ovf, r};
    endfunction

    task automatic queue_op(alu_op_t op, data_t a, data_t b);
        logic [DATA_W:0] e;
        e = model_alu(op, a, b);
        pend_op.push_back(op);
        pend_a.push_back(a);
        pend_b.push_back(b);
        exp_data.push_back(e[DATA_W-1:0]);
        exp_ovf.push_back(e[DATA_W]);
        queued_cnt++;
    endtask

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic wait_drained();
        while (checked_cnt < queued_cnt) begin
            @(posedge clk);
        end
    endtask

    ////////////////////////////////////////
    // scoreboard, sink and source
    ////////////////////////////////////////

    task automatic check_result();
        data_t e_data;
        logic  e_ovf;
        if (res_valid) begin
            assert (exp_data.size() > 0) else begin
                $display("** Error at %0t: result arrived with nothing outstanding", $time);
                abort_run();
            end
            e_data = exp_data.pop_front();
            e_ovf  = exp_ovf.pop_front();
            assert (res_data === e_data) else begin
                $display("** Error at %0t: res_data expected %h, got %h",
                         $time, e_data, res_data);
                abort_run();
            end
            assert (res_ovf === e_ovf) else begin
                $display("** Error at %0t: res_ovf expected %b, got %b",
                         $time, e_ovf, res_ovf);
                abort_run();
            end
            checked_cnt++;
            sink_dly.push_back({$random(seed)} % 6);
        end
    endtask

    task automatic drive_sink();
        out_credit = 1'b0;
        // only the head result counts down, so credits return in order
        if (!sink_hold && sink_dly.size() > 0) begin
            if (sink_dly[0] == 0) begin
                void'(sink_dly.pop_front());
                out_credit = 1'b1;
                credits_back++;
            end else begin
                sink_dly[0] = sink_dly[0] - 1;
            end
        end
        assert (checked_cnt - credits_back <= OUT_CREDITS) else begin
            $display("** Error at %0t: outstanding results expected at most %0d, got %0d",
                     $time, OUT_CREDITS, checked_cnt - credits_back);
            abort_run();
        end
    endtask

    task automatic drive_source();
        if (in_credit) begin
            src_cnt++;
            credit_pulses++;
        end
        in_valid = 1'b0;
        // send only with a credit in hand, with the odd idle cycle
        if (src_cnt > 0 && pend_op.size() > 0 && ({$random(seed)} % 8 != 0)) begin
            in_valid = 1'b1;
            in_op    = pend_op.pop_front();
            in_a     = pend_a.pop_front();
            in_b     = pend_b.pop_front();
            src_cnt--;
            sent_cnt++;
        end
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            check_result();
            drive_sink();
            drive_source();
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        data_t a;
        data_t b;
        int    k;
        seed       = 32'h455;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_op      = op_nop0;
        in_a       = '0;
        in_b       = '0;
        out_credit = 1'b0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        // idle pipeline stays quiet
        repeat (20) begin
            @(negedge clk);
            assert (res_valid === 1'b0) else begin
                $display("** Error at %0t: res_valid expected 0, got %b", $time, res_valid);
                abort_run();
            end
            assert (in_credit === 1'b0) else begin
                $display("** Error at %0t: in_credit expected 0, got %b", $time, in_credit);
                abort_run();
            end
        end
        @(posedge clk);

        // add, sub, rsb, mul
        for (int n = 0; n < N_ARITH; n++) begin
            k = {$random(seed)} % 4;
            a = $random(seed);
            b = $random(seed);
            queue_op(alu_op_t'(k), a, b);
        end
        wait_drained();

        // bitwise ops and the four nops
        for (int n = 0; n < N_LOGIC; n++) begin
            k = {$random(seed)} % 8;
            a = $random(seed);
            b = $random(seed);
            queue_op((k < 4) ? alu_op_t'(op_nor + k) : alu_op_t'(op_nop0 + k - 4), a, b);
        end
        wait_drained();

        // every shift amount for each shift and rotate
        for (int amt = 0; amt < 8; amt++) begin
            for (int s = 0; s < 4; s++) begin
                repeat (5) begin
                    a      = $random(seed);
                    b      = $random(seed);
                    b[2:0] = amt;
                    queue_op(alu_op_t'(op_srl + s), a, b);
                end
            end
        end
        wait_drained();

        // any opcode while the sink sits on its credits for long stretches
        for (int n = 0; n < N_FLOW; n++) begin
            k = {$random(seed)} % 16;
            a = $random(seed);
            b = $random(seed);
            queue_op(alu_op_t'(k), a, b);
        end
        while (checked_cnt < queued_cnt) begin
            sink_hold = 1'b1;
            repeat (20 + {$random(seed)} % 40) @(posedge clk);
            sink_hold = 1'b0;
            repeat (5 + {$random(seed)} % 10) @(posedge clk);
        end
        repeat (5) @(posedge clk);

        assert (credit_pulses == sent_cnt) else begin
            $display("** Error at %0t: in_credit pulses expected %0d, got %0d",
                     $time, sent_cnt, credit_pulses);
            abort_run();
        end
        $display("Simulation PASSED");
        $finish;
    end

    // watchdog
    initial begin
        repeat (MAX_CYC) @(posedge clk);
        $display("timeout: operations still outstanding after %0d cycles", MAX_CYC);
        abort_run();
    end

endmodule

// File: verilog.f
alu_pkg.sv
alu_issue.sv
mult_layer.sv
alu_result.sv
alu_top.sv
alu_checker.sv
tb_alu_top.sv

// File: Bender.yml
package:
  name: alu_top

sources:
  - alu_pkg.sv
  - alu_issue.sv
  - mult_layer.sv
  - alu_result.sv
  - alu_top.sv
  - target: test
    files:
      - alu_checker.sv
      - tb_alu_top.sv
